// File: include/csr_consts.svh
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// Widths
`define CSR_NUM_W        14
`define CSR_DATA_W       32
`define INT_NUM          13

// CSR numbers
`define CSR_CRMD         14'h0
`define CSR_PRMD         14'h1
`define CSR_ECFG         14'h4
`define CSR_ESTAT        14'h5
`define CSR_ERA          14'h6
`define CSR_EENTRY       14'hc
`define CSR_SAVE0        14'h30
`define CSR_SAVE1        14'h31
`define CSR_SAVE2        14'h32
`define CSR_SAVE3        14'h33
`define CSR_TCFG         14'h41
`define CSR_TVAL         14'h42
`define CSR_TICLR        14'h44

// Field ranges
`define CSR_CRMD_PLV     1:0
`define CSR_CRMD_IE      2
`define CSR_PRMD_PPLV    1:0
`define CSR_PRMD_PIE     2
`define CSR_ESTAT_IS10   1:0
`define CSR_EENTRY_VA    31:6
`define CSR_ECFG_LIE     12:0
`define CSR_TCFG_EN      0
`define CSR_TCFG_PERIOD  1
`define CSR_TCFG_INITV   31:2
`define CSR_TICLR_CLR    0

// LIE bit 10 is reserved
`define ECFG_LIE_MASK    13'h1bff

// Counter value while the timer is stopped
`define TIMER_IDLE       32'hffffffff

`endif

// File: verilog/csr_pkg.sv
`include "csr_consts.svh"

package csr_pkg;

    // TCFG layout, msb first
    typedef struct packed {
        logic [29:0] initval;
        logic        periodic;
        logic        en;
    } tcfg_t;

    // One CSR word seen either as bits or as TCFG fields
    typedef union packed {
        logic [`CSR_DATA_W-1:0] raw;
        tcfg_t                  tcfg;
    } csr_word_u;

endpackage

// File: verilog/csr_wr_if.sv
`timescale 1ns/1ps
`include "csr_consts.svh"

interface csr_wr_if;

    logic [`CSR_NUM_W-1:0]  num;
    logic                   we;
    logic [`CSR_DATA_W-1:0] wmask;
    logic [`CSR_DATA_W-1:0] wvalue;

    // Driving side, the CSR access port
    modport host (
        output num, we, wmask, wvalue
    );

    // Register groups only listen
    modport unit (
        input num, we, wmask, wvalue
    );

endinterface

// File: verilog/csr_exc_regs.sv
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_exc_regs (
    input  logic                   clk,
    input  logic                   resetn,
    csr_wr_if.unit                 wr,
    input  logic                   ertn_flush,
    input  logic                   wb_ex,
    input  logic [5:0]             wb_ecode,
    input  logic [8:0]             wb_esubcode,
    input  logic [31:0]            wb_pc,
    input  logic [`INT_NUM-1:0]    is,
    input  logic [`CSR_DATA_W-1:0] tcfg_rdata,
    input  logic [`CSR_DATA_W-1:0] tval_rdata,
    output logic                   ie,
    output logic [`INT_NUM-1:0]    lie,
    output logic [`CSR_DATA_W-1:0] csr_rvalue,
    output logic [`CSR_DATA_W-1:0] ex_entry
);

    logic [1:0]             crmd_plv;
    logic                   crmd_ie;
    logic [1:0]             prmd_pplv;
    logic                   prmd_pie;
    logic [5:0]             estat_ecode;
    logic [8:0]             estat_esubcode;
    logic [31:0]            era_pc;
    logic [25:0]            eentry_va;
    logic [`INT_NUM-1:0]    ecfg_lie;
    logic [`CSR_DATA_W-1:0] save_q [4];

    logic [`CSR_DATA_W-1:0] crmd_word;
    logic [`CSR_DATA_W-1:0] prmd_word;
    logic [`CSR_DATA_W-1:0] estat_word;
    logic [`CSR_DATA_W-1:0] eentry_word;
    logic [`CSR_DATA_W-1:0] ecfg_word;
    logic [`CSR_DATA_W-1:0] crmd_new;
    logic [`CSR_DATA_W-1:0] prmd_new;
    logic [`CSR_DATA_W-1:0] eentry_new;
    logic [`CSR_DATA_W-1:0] ecfg_new;

    function automatic logic [`CSR_DATA_W-1:0] masked(
        input logic [`CSR_DATA_W-1:0] old,
        input logic [`CSR_DATA_W-1:0] mask,
        input logic [`CSR_DATA_W-1:0] value
    );
        return (mask & value) | (~mask & old);
    endfunction

    // DA reads one, paging and access types stay zero
    assign crmd_word   = {28'b0, 1'b1, crmd_ie, crmd_plv};
    assign prmd_word   = {29'b0, prmd_pie, prmd_pplv};
    assign estat_word  = {1'b0, estat_esubcode, estat_ecode, 3'b0, is};
    assign eentry_word = {eentry_va, 6'b0};
    assign ecfg_word   = {19'b0, ecfg_lie};

    assign crmd_new   = masked(crmd_word, wr.wmask, wr.wvalue);
    assign prmd_new   = masked(prmd_word, wr.wmask, wr.wvalue);
    assign eentry_new = masked(eentry_word, wr.wmask, wr.wvalue);
    assign ecfg_new   = masked(ecfg_word, wr.wmask, wr.wvalue);

    // Exception entry first, then return, then software
    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_plv  <= 2'b0;
            crmd_ie   <= 1'b0;
            prmd_pplv <= 2'b0;
            prmd_pie  <= 1'b0;
        end else if (wb_ex) begin
            crmd_plv  <= 2'b0;
            crmd_ie   <= 1'b0;
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr.we && wr.num == `CSR_CRMD) begin
            crmd_plv <= crmd_new[`CSR_CRMD_PLV];
            crmd_ie  <= crmd_new[`CSR_CRMD_IE];
        end else if (wr.we && wr.num == `CSR_PRMD) begin
            prmd_pplv <= prmd_new[`CSR_PRMD_PPLV];
            prmd_pie  <= prmd_new[`CSR_PRMD_PIE];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            estat_ecode    <= 6'b0;
            estat_esubcode <= 9'b0;
            era_pc         <= 32'b0;
        end else if (wb_ex) begin
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
            era_pc         <= wb_pc;
        end else if (wr.we && wr.num == `CSR_ERA) begin
            era_pc <= masked(era_pc, wr.wmask, wr.wvalue);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            eentry_va <= 26'b0;
            ecfg_lie  <= '0;
        end else if (wr.we && wr.num == `CSR_EENTRY) begin
            eentry_va <= eentry_new[`CSR_EENTRY_VA];
        end else if (wr.we && wr.num == `CSR_ECFG) begin
            ecfg_lie <= ecfg_new[`CSR_ECFG_LIE] & `ECFG_LIE_MASK;
        end
    end

    // Scratch words sit at consecutive numbers
    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < 4; i++) begin
                save_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (wr.we && wr.num == `CSR_SAVE0 + `CSR_NUM_W'(i))
                    save_q[i] <= masked(save_q[i], wr.wmask, wr.wvalue);
            end
        end
    end

    always_comb begin
        case (wr.num)
            `CSR_CRMD:   csr_rvalue = crmd_word;
            `CSR_PRMD:   csr_rvalue = prmd_word;
            `CSR_ESTAT:  csr_rvalue = estat_word;
            `CSR_ERA:    csr_rvalue = era_pc;
            `CSR_EENTRY: csr_rvalue = eentry_word;
            `CSR_SAVE0:  csr_rvalue = save_q[0];
            `CSR_SAVE1:  csr_rvalue = save_q[1];
            `CSR_SAVE2:  csr_rvalue = save_q[2];
            `CSR_SAVE3:  csr_rvalue = save_q[3];
            `CSR_ECFG:   csr_rvalue = ecfg_word;
            `CSR_TCFG:   csr_rvalue = tcfg_rdata;
            `CSR_TVAL:   csr_rvalue = tval_rdata;
            `CSR_TICLR:  csr_rvalue = '0;
            default:     csr_rvalue = '0;
        endcase
    end

    assign ex_entry = eentry_word;
    assign ie       = crmd_ie;
    assign lie      = ecfg_lie;

endmodule

// File: verilog/csr_timer.sv
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_timer (
    input  logic                   clk,
    input  logic                   resetn,
    csr_wr_if.unit                 wr,
    output logic [`CSR_DATA_W-1:0] tcfg_rdata,
    output logic [`CSR_DATA_W-1:0] tval_rdata,
    output logic                   timer_en,
    output logic                   timer_zero
);

    import csr_pkg::*;

    csr_word_u              tcfg_q;
    csr_word_u              tcfg_next;
    logic                   tcfg_hit;
    logic [`CSR_DATA_W-1:0] timer_cnt;

    assign tcfg_hit = wr.we && wr.num == `CSR_TCFG;

    // TCFG value as it stands after this cycle's write
    assign tcfg_next.raw = (wr.wmask & wr.wvalue) | (~wr.wmask & tcfg_q.raw);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            tcfg_q.raw <= '0;
        end else if (tcfg_hit) begin
            tcfg_q <= tcfg_next;
        end
    end

    // Load on enable, otherwise count down until idle
    always_ff @(posedge clk) begin
        if (!resetn) begin
            timer_cnt <= `TIMER_IDLE;
        end else if (tcfg_hit && tcfg_next.raw[`CSR_TCFG_EN]) begin
            timer_cnt <= {tcfg_next.tcfg.initval, 2'b0};
        end else if (tcfg_q.tcfg.en && timer_cnt != `TIMER_IDLE) begin
            if (timer_cnt == '0 && tcfg_q.raw[`CSR_TCFG_PERIOD])
                timer_cnt <= {tcfg_q.raw[`CSR_TCFG_INITV], 2'b0};
            else
                // One-shot wraps to idle here
                timer_cnt <= timer_cnt - 1'b1;
        end
    end

    assign tcfg_rdata = tcfg_q.raw;
    assign tval_rdata = timer_cnt;
    assign timer_en   = tcfg_q.tcfg.en;
    assign timer_zero = timer_cnt == '0;

endmodule

// File: verilog/csr_int_ctrl.sv
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_int_ctrl (
    input  logic                clk,
    input  logic                resetn,
    csr_wr_if.unit              wr,
    input  logic [7:0]          hw_int_in,
    input  logic                ipi_int_in,
    input  logic                timer_en,
    input  logic                timer_zero,
    input  logic                ie,
    input  logic [`INT_NUM-1:0] lie,
    output logic [`INT_NUM-1:0] is,
    output logic                has_int
);

    logic [1:0] sw_is;
    logic [7:0] hw_is;
    logic       ipi_is;
    logic       tiflag;
    logic       ticlr;

    assign ticlr = wr.we && wr.num == `CSR_TICLR
                   && wr.wmask[`CSR_TICLR_CLR] && wr.wvalue[`CSR_TICLR_CLR];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            sw_is  <= 2'b0;
            hw_is  <= 8'b0;
            ipi_is <= 1'b0;
            tiflag <= 1'b0;
        end else begin
            if (wr.we && wr.num == `CSR_ESTAT)
                sw_is <= (wr.wmask[`CSR_ESTAT_IS10] & wr.wvalue[`CSR_ESTAT_IS10])
                         | (~wr.wmask[`CSR_ESTAT_IS10] & sw_is);
            // External lines land one cycle late
            hw_is  <= hw_int_in;
            ipi_is <= ipi_int_in;
            if (timer_en && timer_zero)
                tiflag <= 1'b1;
            else if (ticlr)
                tiflag <= 1'b0;
        end
    end

    assign is      = {ipi_is, tiflag, 1'b0, hw_is, sw_is};
    assign has_int = |(is & lie) && ie;

endmodule

// File: verilog/csr_top.sv
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_top (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic [`CSR_NUM_W-1:0]  csr_num,
    input  logic                   csr_we,
    input  logic [`CSR_DATA_W-1:0] csr_wmask,
    input  logic [`CSR_DATA_W-1:0] csr_wvalue,
    input  logic                   ertn_flush,
    input  logic                   wb_ex,
    input  logic [5:0]             wb_ecode,
    input  logic [8:0]             wb_esubcode,
    input  logic [31:0]            wb_pc,
    input  logic [7:0]             hw_int_in,
    input  logic                   ipi_int_in,
    output logic [`CSR_DATA_W-1:0] csr_rvalue,
    output logic [`CSR_DATA_W-1:0] ex_entry,
    output logic                   has_int
);

    logic                   ie;
    logic [`INT_NUM-1:0]    lie;
    logic [`INT_NUM-1:0]    is;
    logic [`CSR_DATA_W-1:0] tcfg_rdata;
    logic [`CSR_DATA_W-1:0] tval_rdata;
    logic                   timer_en;
    logic                   timer_zero;

    csr_wr_if wr_bus ();

    assign wr_bus.num    = csr_num;
    assign wr_bus.we     = csr_we;
    assign wr_bus.wmask  = csr_wmask;
    assign wr_bus.wvalue = csr_wvalue;

    csr_exc_regs i_exc_regs (
        .clk(clk), .resetn(resetn), .wr(wr_bus.unit),
        .ertn_flush(ertn_flush), .wb_ex(wb_ex),
        .wb_ecode(wb_ecode), .wb_esubcode(wb_esubcode), .wb_pc(wb_pc),
        .is(is), .tcfg_rdata(tcfg_rdata), .tval_rdata(tval_rdata),
        .ie(ie), .lie(lie), .csr_rvalue(csr_rvalue), .ex_entry(ex_entry)
    );

    csr_timer i_timer (
        .clk(clk), .resetn(resetn), .wr(wr_bus.unit),
        .tcfg_rdata(tcfg_rdata), .tval_rdata(tval_rdata),
        .timer_en(timer_en), .timer_zero(timer_zero)
    );

    csr_int_ctrl i_int_ctrl (
        .clk(clk), .resetn(resetn), .wr(wr_bus.unit),
        .hw_int_in(hw_int_in), .ipi_int_in(ipi_int_in),
        .timer_en(timer_en), .timer_zero(timer_zero),
        .ie(ie), .lie(lie), .is(is), .has_int(has_int)
    );

endmodule

// File: dv/csr_checker.sv
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_checker (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic [`CSR_NUM_W-1:0]  csr_num,
    input  logic                   csr_we,
    input  logic [`CSR_DATA_W-1:0] csr_wmask,
    input  logic [`CSR_DATA_W-1:0] csr_wvalue,
    input  logic                   ertn_flush,
    input  logic                   wb_ex,
    input  logic [5:0]             wb_ecode,
    input  logic [8:0]             wb_esubcode,
    input  logic [31:0]            wb_pc,
    input  logic [7:0]             hw_int_in,
    input  logic                   ipi_int_in,
    input  logic [`CSR_DATA_W-1:0] csr_rvalue,
    input  logic [`CSR_DATA_W-1:0] ex_entry,
    input  logic                   has_int,
    output int                     err_count
);

    // Architectural state of the model
    typedef struct packed {
        logic [2:0]        crmd;
        logic [2:0]        prmd;
        logic [14:0]       code;
        logic [31:0]       era;
        logic [25:0]       eva;
        logic [12:0]       lie;
        logic [3:0][31:0]  save;
        logic [31:0]       tcfg;
        logic [31:0]       cnt;
        logic [12:0]       is;
    } model_t;

    model_t st;
    logic   live = 1'b0;
    int     errors = 0;

    assign err_count = errors;

    function automatic logic [31:0] written_value(input logic [13:0] num, input logic [31:0] old);
        if (csr_we && csr_num == num)
            return (csr_wvalue & csr_wmask) | (old & ~csr_wmask);
        return old;
    endfunction

    function automatic model_t ref_step(input model_t s);
        model_t      n;
        logic [31:0] w;
        int          i;
        n = s;
        w = written_value(`CSR_CRMD, {29'b0, s.crmd});
        if (!wb_ex && !ertn_flush)
            n.crmd = w[2:0];
        w = written_value(`CSR_PRMD, {29'b0, s.prmd});
        if (!wb_ex && !ertn_flush)
            n.prmd = w[2:0];
        n.era = written_value(`CSR_ERA, s.era);
        if (wb_ex) begin
            n.crmd = 3'b000;
            n.prmd = s.crmd;
            n.code = {wb_esubcode, wb_ecode};
            n.era  = wb_pc;
        end else if (ertn_flush) begin
            n.crmd = s.prmd;
        end
        w = written_value(`CSR_EENTRY, {s.eva, 6'b0});
        n.eva = w[31:6];
        w = written_value(`CSR_ECFG, {19'b0, s.lie});
        n.lie = w[12:0] & 13'h1bff;
        for (i = 0; i < 4; i++)
            n.save[i] = written_value(`CSR_SAVE0 + i[13:0], s.save[i]);
        // Interrupt status lines
        w = written_value(`CSR_ESTAT, {19'b0, s.is});
        n.is[1:0]  = w[1:0];
        n.is[9:2]  = hw_int_in;
        n.is[10]   = 1'b0;
        n.is[12]   = ipi_int_in;
        if (s.tcfg[0] && s.cnt == 32'h0)
            n.is[11] = 1'b1;
        else if (csr_we && csr_num == `CSR_TICLR && csr_wmask[0] && csr_wvalue[0])
            n.is[11] = 1'b0;
        // Timer
        n.tcfg = written_value(`CSR_TCFG, s.tcfg);
        if (csr_we && csr_num == `CSR_TCFG && n.tcfg[0])
            n.cnt = {n.tcfg[31:2], 2'b00};
        else if (s.tcfg[0] && s.cnt != 32'hffffffff)
            n.cnt = (s.cnt == 32'h0 && s.tcfg[1]) ? {s.tcfg[31:2], 2'b00} : s.cnt - 1;
        return n;
    endfunction

    function automatic logic [31:0] ref_read(input model_t s, input logic [13:0] num);
        case (num)
            14'h00:  return {28'b0, 1'b1, s.crmd};
            14'h01:  return {29'b0, s.prmd};
            14'h04:  return {19'b0, s.lie};
            14'h05:  return {1'b0, s.code, 3'b0, s.is};
            14'h06:  return s.era;
            14'h0c:  return {s.eva, 6'b0};
            14'h30:  return s.save[0];
            14'h31:  return s.save[1];
            14'h32:  return s.save[2];
            14'h33:  return s.save[3];
            14'h41:  return s.tcfg;
            14'h42:  return s.cnt;
            default: return 32'h0;
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    always @(posedge clk) begin
        if (!resetn) begin
            st = '0;
            st.cnt = 32'hffffffff;
            live = 1'b1;
        end else if (live) begin
            st = ref_step(st);
        end
    end

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (live) begin
            compare("csr_rvalue", ref_read(st, csr_num), csr_rvalue);
            compare("ex_entry", {st.eva, 6'b0}, ex_entry);
            compare("has_int", {31'b0, st.crmd[2] && |(st.is & st.lie)}, {31'b0, has_int});
        end
    end

endmodule

// File: dv/tb_csr.sv
`timescale 1ns/1ps
`include "csr_consts.svh"

module tb_csr;

    localparam int TEST_CYCLES = 4 + 72 + 72 + 20 + 35 + 45 + 80;
    localparam int WATCHDOG_NS = (TEST_CYCLES + 200) * 10;

    logic        clk;
    logic        resetn;
    logic [13:0] csr_num;
    logic        csr_we;
    logic [31:0] csr_wmask;
    logic [31:0] csr_wvalue;
    logic        ertn_flush;
    logic        wb_ex;
    logic [5:0]  wb_ecode;
    logic [8:0]  wb_esubcode;
    logic [31:0] wb_pc;
    logic [7:0]  hw_int_in;
    logic        ipi_int_in;
    logic [31:0] csr_rvalue;
    logic [31:0] ex_entry;
    logic        has_int;
    logic [31:0] r;
    integer      seed;
    int          err_count;
    int          seq_errors;

    csr_top i_dut (.*);
    csr_checker i_chk (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the test sequence finished");
        $display("sim failed");
        $finish;
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic read_csr(input logic [13:0] num);
        csr_num = num;
        step();
    endtask

    // Write strobe for one cycle, then one cycle of readback
    task automatic write_csr(input logic [13:0] num, input logic [31:0] mask,
                             input logic [31:0] value);
        csr_num    = num;
        csr_we     = 1'b1;
        csr_wmask  = mask;
        csr_wvalue = value;
        step();
        csr_we = 1'b0;
        step();
    endtask

    task automatic raise_exception();
        r           = $random(seed);
        wb_ex       = 1'b1;
        wb_ecode    = r[5:0];
        wb_esubcode = r[14:6];
        wb_pc       = $random(seed);
        step();
        wb_ex  = 1'b0;
        csr_we = 1'b0;
        step();
    endtask

    task automatic return_from_exception();
        ertn_flush = 1'b1;
        step();
        ertn_flush = 1'b0;
        csr_we     = 1'b0;
        step();
    endtask

    task automatic wait_read(input logic [31:0] value, input int limit);
        int n;
        n = 0;
        while (csr_rvalue !== value && n < limit) begin
            step();
            n++;
        end
        if (csr_rvalue !== value) begin
            seq_errors++;
            $display("CSR %h did not reach %h within %0d cycles", csr_num, value, limit);
        end
    endtask

    initial begin
        seed        = 32'ha6b388a6;
        seq_errors  = 0;
        resetn      = 1'b0;
        csr_num     = '0;
        csr_we      = 1'b0;
        csr_wmask   = '0;
        csr_wvalue  = '0;
        ertn_flush  = 1'b0;
        wb_ex       = 1'b0;
        wb_ecode    = '0;
        wb_esubcode = '0;
        wb_pc       = '0;
        hw_int_in   = '0;
        ipi_int_in  = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        resetn = 1'b1;

        // Reset values, unknown numbers included
        for (logic [13:0] a = 0; a < 14'h48; a++)
            read_csr(a);
        repeat (4) begin
            write_csr(`CSR_SAVE0, $random(seed), $random(seed));
            write_csr(`CSR_SAVE1, $random(seed), $random(seed));
            write_csr(`CSR_SAVE2, $random(seed), $random(seed));
            write_csr(`CSR_SAVE3, $random(seed), $random(seed));
            write_csr(`CSR_EENTRY, $random(seed), $random(seed));
            write_csr(`CSR_ECFG, $random(seed), $random(seed));
            write_csr(`CSR_PRMD, $random(seed), $random(seed));
            write_csr(`CSR_CRMD, $random(seed), $random(seed));
            write_csr(`CSR_ECFG, 32'hffffffff, 32'hffffffff);
        end

        // Exception entry and return, each against a CRMD write
        write_csr(`CSR_CRMD, 32'h7, 32'h7);
        write_csr(`CSR_PRMD, 32'h7, 32'h2);
        csr_num    = `CSR_CRMD;
        csr_we     = 1'b1;
        csr_wmask  = 32'h7;
        csr_wvalue = 32'h5;
        raise_exception();
        read_csr(`CSR_PRMD);
        read_csr(`CSR_ESTAT);
        read_csr(`CSR_ERA);
        csr_num = `CSR_CRMD;
        csr_we  = 1'b1;
        csr_wvalue = 32'h0;
        return_from_exception();

        // One-shot timer runs to idle, TICLR drops the flag
        write_csr(`CSR_TCFG, 32'hffffffff, {30'd5, 2'b01});
        read_csr(`CSR_TVAL);
        wait_read(`TIMER_IDLE, 40);
        // Counter must hold at idle
        repeat (3) step();
        read_csr(`CSR_ESTAT);
        write_csr(`CSR_TICLR, 32'h1, 32'h1);

        // Periodic timer fires twice
        write_csr(`CSR_TCFG, 32'hffffffff, {30'd3, 2'b11});
        read_csr(`CSR_TVAL);
        wait_read(32'h0, 20);
        read_csr(`CSR_ESTAT);
        write_csr(`CSR_TICLR, 32'h1, 32'h1);
        read_csr(`CSR_TVAL);
        wait_read(32'h0, 20);
        read_csr(`CSR_ESTAT);
        step();
        write_csr(`CSR_TCFG, 32'h1, 32'h0);

        // Interrupt lines under LIE and IE
        write_csr(`CSR_CRMD, 32'h4, 32'h4);
        repeat (4) begin
            write_csr(`CSR_ECFG, 32'h1fff, $random(seed));
            write_csr(`CSR_ESTAT, 32'h3, $random(seed));
            repeat (8) begin
                r          = $random(seed);
                hw_int_in  = r[7:0];
                ipi_int_in = r[8];
                step();
            end
        end
        hw_int_in = 8'hff;
        write_csr(`CSR_ECFG, 32'h1fff, 32'h1fff);
        raise_exception();
        read_csr(`CSR_ESTAT);
        step();

        $display("checker errors: %0d, sequence errors: %0d", err_count, seq_errors);
        if (err_count == 0 && seq_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+include
verilog/csr_pkg.sv
verilog/csr_wr_if.sv
verilog/csr_exc_regs.sv
verilog/csr_timer.sv
verilog/csr_int_ctrl.sv
verilog/csr_top.sv
dv/csr_checker.sv
dv/tb_csr.sv

// File: Bender.yml
package:
  name: csr_core

sources:
  - include_dirs:
      - include
    files:
      - verilog/csr_pkg.sv
      - verilog/csr_wr_if.sv
      - verilog/csr_exc_regs.sv
      - verilog/csr_timer.sv
      - verilog/csr_int_ctrl.sv
      - verilog/csr_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/csr_checker.sv
      - dv/tb_csr.sv
